// File: list.f
rtl/uart_pkg.sv
rtl/uart_ctrl_if.sv
rtl/uart_regs.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_top.sv
dv/uart_assertions.sv
dv/uart_tb.sv

// File: dv/uart_golden.txt
# W/R: offset data error | S: byte parity stop | P: offset mask value (poll)
# L: loopback 0/1 | I: interrupts {parity,frame,overflow,tx_empty} | T: test name
T regs
W 00 00080003 0
R 00 00080003 0
W 14 0000000e 0
R 14 0000000e 0
R 20 00000000 1
W 24 12345678 1
T loopback
L 1
W 08 000000a5 0
P 04 00000002 00000002
R 0c 000000a5 0
R 10 00000001 0
I 0
W 14 0000000f 0
I 1
W 10 00000001 0
I 0
T parity
W 00 00080007 0
W 08 0000003c 0
P 04 00000002 00000002
R 0c 0000003c 0
W 00 0008000f 0
W 08 00000017 0
P 04 00000002 00000002
R 0c 00000017 0
I 1
L 0
S 3c 0 1
I 9
R 0c 0000003c 0
W 10 0000000f 0
I 0
T frame
W 00 00080003 0
S 55 0 0
I 4
R 0c 00000055 0
W 10 00000004 0
I 0
T overflow
S 11 0 1
S 22 0 1
I 2
R 0c 00000022 0
W 10 00000002 0
I 0
T busy
L 1
W 08 00000041 0
R 04 00000001 0
W 08 00000042 1
P 04 00000002 00000002
R 0c 00000041 0
P 04 00000001 00000000
R 04 00000000 0

// File: dv/uart_tb.sv
// UART peripheral testbench driven by a golden script of bus and serial steps
// Checks bus responses, received bytes and interrupt outputs
`timescale 1ns/1ps

module uart_tb;
  import uart_pkg::*;

  localparam int POLL_LIMIT = 500;

  logic             clk_i;
  logic             reset_i;
  logic             tl_a_valid_i;
  logic [2:0]       tl_a_opcode_i;
  logic [SRC_W-1:0] tl_a_source_i;
  logic [31:0]      tl_a_address_i;
  logic [31:0]      tl_a_data_i;
  logic             tl_a_ready_o;
  logic             tl_d_valid_o;
  logic [2:0]       tl_d_opcode_o;
  logic [SRC_W-1:0] tl_d_source_o;
  logic [31:0]      tl_d_data_o;
  logic             tl_d_error_o;
  logic             tl_d_ready_i;
  logic             cio_rx_i;
  logic             cio_tx_o;
  logic             cio_tx_en_o;
  logic             intr_tx_empty_o;
  logic             intr_rx_overflow_o;
  logic             intr_rx_frame_err_o;
  logic             intr_rx_parity_err_o;
  logic             rx_line;
  logic             loopback;
  logic [31:0]      lcg_state;
  int               bit_clks;
  logic             par_en;
  int               checks;
  int               errors;
  int               test_base;
  int               watch_limit;
  string            test_name;

  uart_top DUT (.*);

  assign cio_rx_i = loopback ? cio_tx_o : rx_line;

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #10;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  // One request, then a random stall on ready before the response is taken
  task automatic bus_access(input logic wr, input logic [7:0] off, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    logic [SRC_W-1:0] src;
    int               stall;
    src            = SRC_W'(lcg_next() >> 26);
    stall          = int'(lcg_next() >> 30);
    tl_a_valid_i   = 1'b1;
    tl_a_opcode_i  = wr ? PutFullData : Get;
    tl_a_source_i  = src;
    tl_a_address_i = {24'h0, off};
    tl_a_data_i    = wdata;
    while (!tl_a_ready_o) next_cycle();
    next_cycle();
    tl_a_valid_i = 1'b0;
    check_value("tl_d_valid_o", 1, tl_d_valid_o);
    check_value("tl_a_ready_o", 0, tl_a_ready_o);
    repeat (stall) next_cycle();
    rdata = tl_d_data_o;
    err   = tl_d_error_o;
    check_value("tl_d_source_o", src, tl_d_source_o);
    check_value("tl_d_opcode_o", wr ? AccessAck : AccessAckData, tl_d_opcode_o);
    tl_d_ready_i = 1'b1;
    next_cycle();
    tl_d_ready_i = 1'b0;
    check_value("tl_d_valid_o", 0, tl_d_valid_o);
    check_value("tl_a_ready_o", 1, tl_a_ready_o);
  endtask

  task automatic poll_until(input logic [7:0] off, input logic [31:0] mask,
                            input logic [31:0] val);
    logic [31:0] rd;
    logic        er;
    int          tries;
    tries = 0;
    bus_access(1'b0, off, 32'h0, rd, er);
    while ((rd & mask) != val && tries < POLL_LIMIT) begin
      bus_access(1'b0, off, 32'h0, rd, er);
      tries++;
    end
    checks++;
    assert ((rd & mask) == val) else begin
      $display("Polling offset %h never reached %h under mask %h", off, val, mask);
      errors++;
    end
  endtask

  task automatic drive_bit(input logic b);
    rx_line = b;
    repeat (bit_clks) next_cycle();
  endtask

  // Parity bit goes out only when the DUT has parity enabled
  task automatic send_frame(input logic [7:0] data, input logic par, input logic stop);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) drive_bit(data[i]);
    if (par_en) drive_bit(par);
    drive_bit(stop);
    rx_line = 1'b1;
    repeat (2 * bit_clks) next_cycle();
  endtask

  task automatic report_test();
    if (test_name != "") begin
      if (errors == test_base) $display("Test %s: ok", test_name);
      else $display("Test %s: FAILED with %0d errors", test_name, errors - test_base);
    end
  endtask

  initial begin
    wait (watch_limit > 0);
    repeat (watch_limit) @(posedge clk_i);
    $display("Run stopped by the watchdog after %0d clocks", watch_limit);
    $display("Checks failed");
    $finish;
  end

  initial begin
    string       line;
    int          fd;
    int          n;
    int          lines;
    int          max_div;
    logic [7:0]  cmd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] rd;
    logic        er;
    {tl_a_valid_i, tl_a_opcode_i, tl_a_source_i, tl_a_address_i, tl_a_data_i} = '0;
    tl_d_ready_i = 1'b0;
    rx_line      = 1'b1;
    loopback     = 1'b0;
    reset_i      = 1'b1;
    lcg_state    = 32'hd0c6fff3;
    {checks, errors, test_base, watch_limit, lines} = '0;
    bit_clks     = 2;
    par_en       = 1'b0;
    max_div      = 2;
    test_name    = "";
    // First pass sizes the watchdog from the line count and the largest divisor
    fd = $fopen("dv/uart_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the golden script dv/uart_golden.txt");
      errors++;
    end else begin
      while ($fgets(line, fd)) begin
        lines++;
        a = '0;
        b = '0;
        n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
        if (line[0] == "W" && a[7:0] == CTRL_OFFSET && int'(b[31:16]) > max_div) begin
          max_div = b[31:16];
        end
      end
      $fclose(fd);
      watch_limit = lines * (12 * max_div + 20);
      fd = $fopen("dv/uart_golden.txt", "r");
    end
    repeat (4) @(posedge clk_i);
    #10;
    reset_i = 1'b0;
    // Idle bus, idle line and quiet interrupts out of reset
    test_name = "reset";
    check_value("tl_a_ready_o", 1, tl_a_ready_o);
    check_value("tl_d_valid_o", 0, tl_d_valid_o);
    check_value("cio_tx_o", 1, cio_tx_o);
    check_value("cio_tx_en_o", 0, cio_tx_en_o);
    check_value("intr_*_o", 0, {28'h0, intr_rx_parity_err_o, intr_rx_frame_err_o,
                                intr_rx_overflow_o, intr_tx_empty_o});
    while (fd != 0 && $fgets(line, fd)) begin
      if (line.len() < 2 || line[0] == "#") continue;
      cmd = line[0];
      a   = '0;
      b   = '0;
      c   = '0;
      n   = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
      case (cmd)
        "T": begin
          report_test();
          test_name = line.substr(2, line.len() - 2);
          test_base = errors;
        end
        "W": begin
          bus_access(1'b1, a[7:0], b, rd, er);
          check_value("tl_d_error_o", c, er);
          if (a[7:0] == CTRL_OFFSET && c == 0) begin
            bit_clks = b[31:16];
            par_en   = b[CTRL_PAR_EN];
            check_value("cio_tx_en_o", b[CTRL_TX_EN], cio_tx_en_o);
          end
        end
        "R": begin
          bus_access(1'b0, a[7:0], 32'h0, rd, er);
          check_value("tl_d_data_o", b, rd);
          check_value("tl_d_error_o", c, er);
        end
        "S": send_frame(a[7:0], b[0], c[0]);
        "P": poll_until(a[7:0], b, c);
        "L": loopback = a[0];
        "I": check_value("intr_*_o", a, {28'h0, intr_rx_parity_err_o, intr_rx_frame_err_o,
                                         intr_rx_overflow_o, intr_tx_empty_o});
        default: begin
          $display("Unknown command in golden script line: %s", line);
          errors++;
        end
      endcase
    end
    report_test();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) $display("All checks passed");
    else $display("Checks failed");
    $finish;
  end

endmodule

// File: dv/uart_assertions.sv
// UART bus handshake and serial line properties
// Bound into the register block and the transmit engine
`timescale 1ns/1ps

module uart_assertions (
  input logic                              clk_i,
  input logic                              reset_i,
  input logic                              a_valid_i,
  input logic                              a_ready_i,
  input logic                              d_valid_i,
  input logic                              d_ready_i,
  input logic [3+uart_pkg::SRC_W+32+1-1:0] d_payload_i,
  input logic                              tx_idle_i,
  input logic                              tx_i
);

  // A waiting response keeps its valid and its payload until the host takes it
  payload_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    d_valid_i && !d_ready_i |=> d_valid_i && $stable(d_payload_i))
    else $error("response changed while waiting for ready");

  no_accept_while_pending: assert property (@(posedge clk_i) disable iff (reset_i)
    a_valid_i && a_ready_i |-> !d_valid_i)
    else $error("request accepted while a response was pending");

  tx_idle_high: assert property (@(posedge clk_i) disable iff (reset_i)
    tx_idle_i |-> tx_i)
    else $error("tx line low while the engine is idle");

endmodule

bind uart_regs uart_assertions u_regs_assertions (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .a_valid_i   (tl_a_valid_i),
  .a_ready_i   (tl_a_ready_o),
  .d_valid_i   (tl_d_valid_o),
  .d_ready_i   (tl_d_ready_i),
  .d_payload_i ({tl_d_opcode_o, tl_d_source_o, tl_d_data_o, tl_d_error_o}),
  .tx_idle_i   (1'b0),
  .tx_i        (1'b1)
);

bind uart_tx uart_assertions u_tx_assertions (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .a_valid_i   (1'b0),
  .a_ready_i   (1'b0),
  .d_valid_i   (1'b0),
  .d_ready_i   (1'b1),
  .d_payload_i ('0),
  .tx_idle_i   (state_q == uart_pkg::TX_IDLE),
  .tx_i        (tx_o)
);

// File: rtl/uart_top.sv
// UART peripheral top level with a flattened TileLink-UL port
// Connects the register block to the transmit and receive engines
`timescale 1ns/1ps

module uart_top (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       tl_a_valid_i,
  input  logic [2:0]                 tl_a_opcode_i,
  input  logic [uart_pkg::SRC_W-1:0] tl_a_source_i,
  input  logic [31:0]                tl_a_address_i,
  input  logic [31:0]                tl_a_data_i,
  output logic                       tl_a_ready_o,
  output logic                       tl_d_valid_o,
  output logic [2:0]                 tl_d_opcode_o,
  output logic [uart_pkg::SRC_W-1:0] tl_d_source_o,
  output logic [31:0]                tl_d_data_o,
  output logic                       tl_d_error_o,
  input  logic                       tl_d_ready_i,
  input  logic                       cio_rx_i,
  output logic                       cio_tx_o,
  output logic                       cio_tx_en_o,
  output logic                       intr_tx_empty_o,
  output logic                       intr_rx_overflow_o,
  output logic                       intr_rx_frame_err_o,
  output logic                       intr_rx_parity_err_o
);
  import uart_pkg::*;

  logic [NUM_INTR-1:0] intr;

  uart_ctrl_if u_ctrl_if ();

  uart_regs u_regs (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .tl_a_valid_i   (tl_a_valid_i),
    .tl_a_opcode_i  (tl_a_opcode_i),
    .tl_a_source_i  (tl_a_source_i),
    .tl_a_address_i (tl_a_address_i),
    .tl_a_data_i    (tl_a_data_i),
    .tl_a_ready_o   (tl_a_ready_o),
    .tl_d_valid_o   (tl_d_valid_o),
    .tl_d_opcode_o  (tl_d_opcode_o),
    .tl_d_source_o  (tl_d_source_o),
    .tl_d_data_o    (tl_d_data_o),
    .tl_d_error_o   (tl_d_error_o),
    .tl_d_ready_i   (tl_d_ready_i),
    .ctrl           (u_ctrl_if.regs),
    .intr_o         (intr)
  );

  uart_tx u_tx (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .ctrl    (u_ctrl_if.engine),
    .tx_o    (cio_tx_o)
  );

  uart_rx u_rx (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .ctrl    (u_ctrl_if.engine),
    .rx_i    (cio_rx_i)
  );

  assign cio_tx_en_o          = u_ctrl_if.tx_en;
  assign intr_tx_empty_o      = intr[TX_EMPTY];
  assign intr_rx_overflow_o   = intr[RX_OVERFLOW];
  assign intr_rx_frame_err_o  = intr[RX_FRAME_ERR];
  assign intr_rx_parity_err_o = intr[RX_PARITY_ERR];

endmodule

// File: rtl/uart_rx.sv
// UART receive engine with start detection, mid-bit sampling and frame checks
`timescale 1ns/1ps

module uart_rx (
  input  logic        clk_i,
  input  logic        reset_i,
  uart_ctrl_if.engine ctrl,
  input  logic        rx_i
);
  import uart_pkg::*;

  rx_state_e        state_q;
  logic [1:0]       sync_q;
  logic             prev_q;
  logic             rx_s;
  logic [DIV_W-1:0] cnt_q;
  logic [DIV_W-1:0] half;
  logic [2:0]       bit_idx_q;
  logic [7:0]       shift_q;
  logic             parity_q;
  logic             par_err_q;
  logic             frame_err_q;
  logic             strobe_q;
  logic             div_ok;
  logic             bit_end;

  // Synchronizer resets to the idle level so no false start appears
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_q <= 2'b11;
      prev_q <= 1'b1;
    end else begin
      sync_q <= {sync_q[0], rx_i};
      prev_q <= sync_q[1];
    end
  end

  assign rx_s    = sync_q[1];
  assign half    = ctrl.divisor >> 1;
  assign div_ok  = (ctrl.divisor >= DIV_W'(2));
  assign bit_end = (cnt_q >= ctrl.divisor - DIV_W'(1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= RX_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      strobe_q  <= 1'b0;
    end else if (!div_ok) begin
      state_q  <= RX_IDLE;
      strobe_q <= 1'b0;
    end else begin
      strobe_q <= 1'b0;
      cnt_q    <= bit_end ? '0 : cnt_q + 1'b1;
      case (state_q)
        RX_IDLE: begin
          cnt_q <= '0;
          if (ctrl.rx_en && prev_q && !rx_s) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          // From mid-start onward every sample lands one full bit later
          if (cnt_q >= half) begin
            cnt_q     <= '0;
            bit_idx_q <= '0;
            state_q   <= rx_s ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            bit_idx_q <= bit_idx_q + 3'd1;
            if (bit_idx_q == 3'd7) begin
              state_q <= ctrl.parity_en ? RX_PARITY : RX_STOP;
            end
          end
        end
        RX_PARITY: if (bit_end) state_q <= RX_STOP;
        RX_STOP: begin
          if (bit_end) begin
            state_q  <= RX_IDLE;
            strobe_q <= 1'b1;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == RX_START) begin
      parity_q  <= ctrl.parity_odd;
      par_err_q <= 1'b0;
    end
    if (state_q == RX_DATA && bit_end) begin
      shift_q  <= {rx_s, shift_q[7:1]};
      parity_q <= parity_q ^ rx_s;
    end
    if (state_q == RX_PARITY && bit_end) begin
      par_err_q <= rx_s ^ parity_q;
    end
    if (state_q == RX_STOP && bit_end) begin
      frame_err_q <= ~rx_s;
    end
  end

  assign ctrl.rx_data       = shift_q;
  assign ctrl.rx_strobe     = strobe_q;
  assign ctrl.rx_frame_err  = strobe_q & frame_err_q;
  assign ctrl.rx_parity_err = strobe_q & par_err_q;

endmodule

// File: rtl/uart_tx.sv
// UART transmit engine, sends one 8N1 frame with optional parity per start pulse
`timescale 1ns/1ps

module uart_tx (
  input  logic        clk_i,
  input  logic        reset_i,
  uart_ctrl_if.engine ctrl,
  output logic        tx_o
);
  import uart_pkg::*;

  tx_state_e        state_q;
  logic [DIV_W-1:0] bit_cnt_q;
  logic [2:0]       bit_idx_q;
  logic [7:0]       shift_q;
  logic             parity_q;
  logic             div_ok;
  logic             bit_end;

  assign div_ok  = (ctrl.divisor >= DIV_W'(2));
  assign bit_end = (bit_cnt_q >= ctrl.divisor - DIV_W'(1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= TX_IDLE;
      bit_cnt_q <= '0;
      bit_idx_q <= '0;
    end else if (!div_ok) begin
      state_q <= TX_IDLE;
    end else begin
      bit_cnt_q <= bit_end ? '0 : bit_cnt_q + 1'b1;
      case (state_q)
        TX_IDLE: begin
          bit_cnt_q <= '0;
          bit_idx_q <= '0;
          if (ctrl.tx_start && ctrl.tx_en) begin
            state_q <= TX_START;
          end
        end
        TX_START: if (bit_end) state_q <= TX_DATA;
        TX_DATA: begin
          if (bit_end) begin
            bit_idx_q <= bit_idx_q + 3'd1;
            if (bit_idx_q == 3'd7) begin
              state_q <= ctrl.parity_en ? TX_PARITY : TX_STOP;
            end
          end
        end
        TX_PARITY: if (bit_end) state_q <= TX_STOP;
        TX_STOP: if (bit_end) state_q <= TX_IDLE;
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  // Parity starts from the odd flag and folds in each bit as it leaves
  always_ff @(posedge clk_i) begin
    if (state_q == TX_IDLE && ctrl.tx_start) begin
      shift_q  <= ctrl.tx_data;
      parity_q <= ctrl.parity_odd;
    end else if (state_q == TX_DATA && bit_end) begin
      shift_q  <= shift_q >> 1;
      parity_q <= parity_q ^ shift_q[0];
    end
  end

  always_comb begin
    case (state_q)
      TX_START:  tx_o = 1'b0;
      TX_DATA:   tx_o = shift_q[0];
      TX_PARITY: tx_o = parity_q;
      default:   tx_o = 1'b1;
    endcase
  end

  assign ctrl.tx_busy = (state_q != TX_IDLE);
  assign ctrl.tx_done = (state_q == TX_STOP) && bit_end;

endmodule

// File: rtl/uart_regs.sv
// UART register block with a single-outstanding TileLink-UL responder
// Keeps CTRL, the rx holding byte and the interrupt state and enable registers
`timescale 1ns/1ps

module uart_regs (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          tl_a_valid_i,
  input  logic [2:0]                    tl_a_opcode_i,
  input  logic [uart_pkg::SRC_W-1:0]    tl_a_source_i,
  input  logic [31:0]                   tl_a_address_i,
  input  logic [31:0]                   tl_a_data_i,
  output logic                          tl_a_ready_o,
  output logic                          tl_d_valid_o,
  output logic [2:0]                    tl_d_opcode_o,
  output logic [uart_pkg::SRC_W-1:0]    tl_d_source_o,
  output logic [31:0]                   tl_d_data_o,
  output logic                          tl_d_error_o,
  input  logic                          tl_d_ready_i,
  uart_ctrl_if.regs                     ctrl,
  output logic [uart_pkg::NUM_INTR-1:0] intr_o
);
  import uart_pkg::*;

  logic                accept;
  logic                is_read;
  logic                addr_hit;
  logic                req_err;
  logic                wr_ok;
  logic                rx_rd;
  logic                tx_pending;
  logic [7:0]          offset;
  logic [31:0]         rdata;
  logic                tx_en_q;
  logic                rx_en_q;
  logic                par_en_q;
  logic                par_odd_q;
  logic [DIV_W-1:0]    divisor_q;
  logic                tx_start_q;
  logic [7:0]          tx_data_q;
  logic                rx_valid_q;
  logic [7:0]          rx_byte_q;
  logic [NUM_INTR-1:0] intr_state_q;
  logic [NUM_INTR-1:0] intr_enable_q;
  logic [NUM_INTR-1:0] intr_set;
  logic [NUM_INTR-1:0] intr_clr;
  tl_d_op_e            d_opcode_q;

  // Only one request in flight, so the response slot doubles as the busy flag
  assign tl_a_ready_o = ~tl_d_valid_o;
  assign accept       = tl_a_valid_i & tl_a_ready_o;
  assign is_read      = (tl_a_opcode_i == Get);
  assign offset       = tl_a_address_i[7:0];
  // A start pulse in flight counts as busy before the engine has seen it
  assign tx_pending   = ctrl.tx_busy | tx_start_q;

  always_comb begin
    addr_hit = 1'b1;
    rdata    = '0;
    case (offset)
      CTRL_OFFSET: begin
        rdata[CTRL_TX_EN]                 = tx_en_q;
        rdata[CTRL_RX_EN]                 = rx_en_q;
        rdata[CTRL_PAR_EN]                = par_en_q;
        rdata[CTRL_PAR_ODD]               = par_odd_q;
        rdata[CTRL_DIV_LSB +: DIV_W]      = divisor_q;
      end
      STATUS_OFFSET: begin
        rdata[STATUS_TX_BUSY]  = tx_pending;
        rdata[STATUS_RX_VALID] = rx_valid_q;
      end
      WDATA_OFFSET:       rdata = '0;
      RDATA_OFFSET:       rdata[7:0] = rx_byte_q;
      INTR_STATE_OFFSET:  rdata[NUM_INTR-1:0] = intr_state_q;
      INTR_ENABLE_OFFSET: rdata[NUM_INTR-1:0] = intr_enable_q;
      default:            addr_hit = 1'b0;
    endcase
  end

  assign req_err = ~addr_hit | (~is_read & (offset == WDATA_OFFSET) & tx_pending);
  assign wr_ok   = accept & ~is_read & ~req_err;
  assign rx_rd   = accept & is_read & (offset == RDATA_OFFSET);

  // Overflow only when the old byte is not being read in the same edge
  assign intr_set[TX_EMPTY]      = ctrl.tx_done;
  assign intr_set[RX_OVERFLOW]   = ctrl.rx_strobe & rx_valid_q & ~rx_rd;
  assign intr_set[RX_FRAME_ERR]  = ctrl.rx_strobe & ctrl.rx_frame_err;
  assign intr_set[RX_PARITY_ERR] = ctrl.rx_strobe & ctrl.rx_parity_err;
  assign intr_clr = (wr_ok && offset == INTR_STATE_OFFSET) ? tl_a_data_i[NUM_INTR-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tx_en_q       <= 1'b0;
      rx_en_q       <= 1'b0;
      par_en_q      <= 1'b0;
      par_odd_q     <= 1'b0;
      divisor_q     <= '0;
      tx_start_q    <= 1'b0;
      rx_valid_q    <= 1'b0;
      intr_state_q  <= '0;
      intr_enable_q <= '0;
      tl_d_valid_o  <= 1'b0;
    end else begin
      tx_start_q   <= wr_ok && (offset == WDATA_OFFSET) && tx_en_q;
      // Hardware set wins over a software clear
      intr_state_q <= (intr_state_q & ~intr_clr) | intr_set;
      if (ctrl.rx_strobe) begin
        rx_valid_q <= 1'b1;
      end else if (rx_rd) begin
        rx_valid_q <= 1'b0;
      end
      if (wr_ok && offset == CTRL_OFFSET) begin
        tx_en_q   <= tl_a_data_i[CTRL_TX_EN];
        rx_en_q   <= tl_a_data_i[CTRL_RX_EN];
        par_en_q  <= tl_a_data_i[CTRL_PAR_EN];
        par_odd_q <= tl_a_data_i[CTRL_PAR_ODD];
        divisor_q <= tl_a_data_i[CTRL_DIV_LSB +: DIV_W];
      end
      if (wr_ok && offset == INTR_ENABLE_OFFSET) begin
        intr_enable_q <= tl_a_data_i[NUM_INTR-1:0];
      end
      if (accept) begin
        tl_d_valid_o <= 1'b1;
      end else if (tl_d_ready_i) begin
        tl_d_valid_o <= 1'b0;
      end
    end
  end

  // Payload registers, loaded on acceptance or strobe
  always_ff @(posedge clk_i) begin
    if (wr_ok && offset == WDATA_OFFSET) begin
      tx_data_q <= tl_a_data_i[7:0];
    end
    if (ctrl.rx_strobe) begin
      rx_byte_q <= ctrl.rx_data;
    end
    if (accept) begin
      d_opcode_q    <= is_read ? AccessAckData : AccessAck;
      tl_d_source_o <= tl_a_source_i;
      tl_d_data_o   <= (is_read && !req_err) ? rdata : '0;
      tl_d_error_o  <= req_err;
    end
  end

  assign tl_d_opcode_o   = d_opcode_q;
  assign intr_o          = intr_state_q & intr_enable_q;
  assign ctrl.divisor    = divisor_q;
  assign ctrl.parity_en  = par_en_q;
  assign ctrl.parity_odd = par_odd_q;
  assign ctrl.tx_en      = tx_en_q;
  assign ctrl.rx_en      = rx_en_q;
  assign ctrl.tx_data    = tx_data_q;
  assign ctrl.tx_start   = tx_start_q;

endmodule

// File: rtl/uart_ctrl_if.sv
// Control and data link between the UART register block and the tx and rx engines
`timescale 1ns/1ps

interface uart_ctrl_if;
  import uart_pkg::*;

  // Configuration
  logic [DIV_W-1:0] divisor;
  logic             parity_en;
  logic             parity_odd;
  logic             tx_en;
  logic             rx_en;

  // Transmit side
  logic [7:0]       tx_data;
  logic             tx_start;
  logic             tx_busy;
  logic             tx_done;

  // Receive side
  logic [7:0]       rx_data;
  logic             rx_strobe;
  logic             rx_frame_err;
  logic             rx_parity_err;

  modport regs (
    output divisor, parity_en, parity_odd, tx_en, rx_en, tx_data, tx_start,
    input  tx_busy, tx_done, rx_data, rx_strobe, rx_frame_err, rx_parity_err
  );

  modport engine (
    input  divisor, parity_en, parity_odd, tx_en, rx_en, tx_data, tx_start,
    output tx_busy, tx_done, rx_data, rx_strobe, rx_frame_err, rx_parity_err
  );

endinterface

// File: rtl/uart_pkg.sv
// UART peripheral definitions shared by the register block and the serial engines
// Holds the register map, bus opcodes, engine states and field widths
package uart_pkg;

  // Field widths
  localparam int DIV_W    = 16;
  localparam int SRC_W    = 6;
  localparam int NUM_INTR = 4;

  // TileLink-UL request and response opcodes
  typedef enum logic [2:0] {
    PutFullData = 3'h0,
    Get         = 3'h4
  } tl_a_op_e;

  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // Register offsets, matched against the low address byte
  localparam logic [7:0] CTRL_OFFSET        = 8'h00;
  localparam logic [7:0] STATUS_OFFSET      = 8'h04;
  localparam logic [7:0] WDATA_OFFSET       = 8'h08;
  localparam logic [7:0] RDATA_OFFSET       = 8'h0C;
  localparam logic [7:0] INTR_STATE_OFFSET  = 8'h10;
  localparam logic [7:0] INTR_ENABLE_OFFSET = 8'h14;

  // CTRL and STATUS field positions
  localparam int CTRL_TX_EN      = 0;
  localparam int CTRL_RX_EN      = 1;
  localparam int CTRL_PAR_EN     = 2;
  localparam int CTRL_PAR_ODD    = 3;
  localparam int CTRL_DIV_LSB    = 16;
  localparam int STATUS_TX_BUSY  = 0;
  localparam int STATUS_RX_VALID = 1;

  // Interrupt bit positions
  localparam int TX_EMPTY      = 0;
  localparam int RX_OVERFLOW   = 1;
  localparam int RX_FRAME_ERR  = 2;
  localparam int RX_PARITY_ERR = 3;

  typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP} tx_state_e;
  typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} rx_state_e;

endpackage
